// File: design/cart_cmd_pkg.sv
package cart_cmd_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   // Full cartridge address as seen by the host
   localparam int ADDR_W = 24;

   // Index width of the on-chip byte array
   localparam int MEM_AW = 12;
   localparam int MEM_DEPTH = 1 << MEM_AW;

   // Byte counter within one SPI transfer, saturating
   localparam int BYTE_CNT_W = 8;
   localparam logic [BYTE_CNT_W-1:0] BYTE_CNT_MAX = '1;
   localparam logic [BYTE_CNT_W-1:0] BYTE_CNT_ONE = 1;

   // Parameter byte positions for the 24-bit register loads
   localparam logic [BYTE_CNT_W-1:0] PARAM_HI  = 1;
   localparam logic [BYTE_CNT_W-1:0] PARAM_MID = 2;
   localparam logic [BYTE_CNT_W-1:0] PARAM_LO  = 3;

   ////////////////////////////////////////////////////////////////////////////
   // Constants
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [ADDR_W-1:0] ADDR_STEP  = 1;
   localparam logic [ADDR_W-1:0] MASK_RESET = '1;

   // Reply byte of the echo probe
   localparam logic [7:0] ECHO_BYTE = 8'hA5;

   // Command bit that turns on address auto-increment
   localparam int AUTO_INC_BIT = 0;

   ////////////////////////////////////////////////////////////////////////////
   // Enums
   ////////////////////////////////////////////////////////////////////////////

   // Opcode in the upper nibble of the command byte
   typedef enum logic [3:0] {
      OP_SET_ADDR      = 4'h0,
      OP_SET_ROM_MASK  = 4'h1,
      OP_SET_SRAM_MASK = 4'h2,
      OP_SET_MAPPER    = 4'h3,
      OP_READ          = 4'h8,
      OP_WRITE         = 4'h9,
      OP_ECHO          = 4'hF
   } cmd_op_e;

   // Where the decoder is within one select-low window
   typedef enum logic [1:0] {
      PH_IDLE,
      PH_CMD,
      PH_DATA
   } xfer_phase_e;

endpackage

// File: design/spi_byte_slave.sv
`timescale 1ns/1ns

module spi_byte_slave (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic                                spi_sck,
   input  logic                                spi_mosi,
   input  logic                                spi_ss_n,
   output logic                                spi_miso,
   input  logic [7:0]                          tx_byte,
   input  logic                                tx_load,
   output logic [7:0]                          rx_byte,
   output logic                                byte_valid,
   output logic [2:0]                          bit_cnt,
   output logic [cart_cmd_pkg::BYTE_CNT_W-1:0] byte_cnt,
   output logic                                xfer_start,
   output logic                                xfer_end
);

   // Two sync stages plus one history stage for edge detect
   logic [2:0] sck_sync;
   logic [2:0] ss_sync;
   logic [1:0] mosi_sync;
   logic       sck_rise;
   logic       sck_fall;
   logic       ss_active;
   logic       mosi_s;
   logic [6:0] rx_shift;
   logic [7:0] tx_shift;
   logic [7:0] tx_hold;
   logic       load_pend;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sck_sync  <= 3'b000;
         ss_sync   <= 3'b111;
         mosi_sync <= 2'b00;
      end else begin
         sck_sync  <= {sck_sync[1:0], spi_sck};
         ss_sync   <= {ss_sync[1:0], spi_ss_n};
         mosi_sync <= {mosi_sync[0], spi_mosi};
      end
   end

   assign sck_rise   = (sck_sync[2:1] == 2'b01);
   assign sck_fall   = (sck_sync[2:1] == 2'b10);
   assign ss_active  = ~ss_sync[1];
   assign mosi_s     = mosi_sync[1];
   assign xfer_start = (ss_sync[2:1] == 2'b10);
   assign xfer_end   = (ss_sync[2:1] == 2'b01);

   ////////////////////////////////////////////////////////////////////////////
   // Receive side, MSB first on rising SCK
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         bit_cnt    <= 3'd0;
         rx_shift   <= 7'd0;
         rx_byte    <= 8'd0;
         byte_valid <= 1'b0;
         byte_cnt   <= '0;
      end else begin
         byte_valid <= 1'b0;
         if (xfer_start) begin
            bit_cnt  <= 3'd0;
            rx_shift <= 7'd0;
            byte_cnt <= '0;
         end else begin
            if (ss_active && sck_rise) begin
               bit_cnt  <= bit_cnt + 3'd1;
               rx_shift <= {rx_shift[5:0], mosi_s};
               if (bit_cnt == 3'd7) begin
                  rx_byte    <= {rx_shift, mosi_s};
                  byte_valid <= 1'b1;
               end
            end
            // Count advances once the completed byte has been seen
            if (byte_valid && byte_cnt != cart_cmd_pkg::BYTE_CNT_MAX) begin
               byte_cnt <= byte_cnt + cart_cmd_pkg::BYTE_CNT_ONE;
            end
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Transmit side, new byte presented on the falling edge after bit 0
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_hold   <= 8'd0;
         tx_shift  <= 8'd0;
         load_pend <= 1'b0;
      end else if (xfer_start || xfer_end) begin
         tx_hold   <= 8'd0;
         tx_shift  <= 8'd0;
         load_pend <= 1'b0;
      end else begin
         if (tx_load) begin
            tx_hold <= tx_byte;
         end
         if (ss_active && sck_rise && bit_cnt == 3'd7) begin
            load_pend <= 1'b1;
         end else if (ss_active && sck_fall) begin
            if (load_pend) begin
               // A load arriving right at the boundary wins
               tx_shift  <= tx_load ? tx_byte : tx_hold;
               load_pend <= 1'b0;
            end else begin
               tx_shift <= {tx_shift[6:0], 1'b0};
            end
         end
      end
   end

   assign spi_miso = tx_shift[7];

   a_valid_in_select: assert property (@(posedge clk) disable iff (!rst_n)
      byte_valid |-> ss_active);

endmodule

// File: design/mcu_cmd.sv
`timescale 1ns/1ns

module mcu_cmd (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [7:0]                          rx_byte,
   input  logic                                byte_valid,
   input  logic [2:0]                          bit_cnt,
   input  logic [cart_cmd_pkg::BYTE_CNT_W-1:0] byte_cnt,
   input  logic                                xfer_start,
   input  logic                                xfer_end,
   output logic [7:0]                          tx_byte,
   output logic                                tx_load,
   output logic [cart_cmd_pkg::MEM_AW-1:0]     mem_addr,
   output logic [7:0]                          mem_wdata,
   output logic                                mem_we_n,
   output logic                                mem_re_n,
   input  logic [7:0]                          mem_rdata,
   input  logic                                dma_ovr,
   input  logic                                dma_we,
   input  logic [7:0]                          dma_data,
   input  logic                                dma_nextaddr,
   output logic [3:0]                          mapper,
   output logic [cart_cmd_pkg::ADDR_W-1:0]     rom_mask,
   output logic [cart_cmd_pkg::ADDR_W-1:0]     sram_mask
);

   cart_cmd_pkg::xfer_phase_e         phase_q;
   cart_cmd_pkg::cmd_op_e             cmd_op_q;
   cart_cmd_pkg::cmd_op_e             rx_op;
   logic [3:0]                        cmd_lo_q;
   logic [cart_cmd_pkg::ADDR_W-1:0]   addr_q;
   logic [7:0]                        wdata_q;
   logic                              we_q;
   logic                              rd_pend_q;
   logic                              fetch_q;
   logic [2:0]                        bit_cnt_q;
   logic [2:0]                        dma_nx_sync;
   logic                              dma_step;
   logic                              cmd_valid;
   logic                              param_valid;
   logic                              rd_active;
   logic                              fetch_now;
   logic                              auto_inc;
   logic                              inc_now;

   assign rx_op       = cart_cmd_pkg::cmd_op_e'(rx_byte[7:4]);
   assign cmd_valid   = byte_valid && (phase_q == cart_cmd_pkg::PH_CMD);
   assign param_valid = byte_valid && (phase_q == cart_cmd_pkg::PH_DATA);
   assign auto_inc    = cmd_lo_q[cart_cmd_pkg::AUTO_INC_BIT];
   assign rd_active   = (phase_q == cart_cmd_pkg::PH_DATA) &&
                        (cmd_op_q == cart_cmd_pkg::OP_READ);

   // First fetch follows the command byte, later ones start at bit 6
   assign fetch_now = rd_pend_q ||
                      (rd_active && bit_cnt == 3'd6 && bit_cnt_q != 3'd6);

   // Write step lands the cycle after the write strobe
   assign inc_now = auto_inc && (fetch_q ||
                    (!we_q && cmd_op_q == cart_cmd_pkg::OP_WRITE));

   assign dma_step = (dma_nx_sync[2:1] == 2'b01);

   ////////////////////////////////////////////////////////////////////////////
   // Transfer phase and command latch
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         phase_q  <= cart_cmd_pkg::PH_IDLE;
         cmd_op_q <= cart_cmd_pkg::OP_SET_ADDR;
         cmd_lo_q <= 4'd0;
      end else if (xfer_end) begin
         phase_q <= cart_cmd_pkg::PH_IDLE;
      end else if (xfer_start) begin
         phase_q <= cart_cmd_pkg::PH_CMD;
      end else if (cmd_valid) begin
         phase_q  <= cart_cmd_pkg::PH_DATA;
         cmd_op_q <= rx_op;
         cmd_lo_q <= rx_byte[3:0];
      end
   end

   // Mapper and mask registers
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mapper    <= 4'd0;
         rom_mask  <= cart_cmd_pkg::MASK_RESET;
         sram_mask <= cart_cmd_pkg::MASK_RESET;
      end else if (cmd_valid && rx_op == cart_cmd_pkg::OP_SET_MAPPER) begin
         mapper <= rx_byte[3:0];
      end else if (param_valid) begin
         case (cmd_op_q)
            cart_cmd_pkg::OP_SET_ROM_MASK: begin
               if (byte_cnt == cart_cmd_pkg::PARAM_HI)  rom_mask[23:16] <= rx_byte;
               if (byte_cnt == cart_cmd_pkg::PARAM_MID) rom_mask[15:8]  <= rx_byte;
               if (byte_cnt == cart_cmd_pkg::PARAM_LO)  rom_mask[7:0]   <= rx_byte;
            end
            cart_cmd_pkg::OP_SET_SRAM_MASK: begin
               if (byte_cnt == cart_cmd_pkg::PARAM_HI)  sram_mask[23:16] <= rx_byte;
               if (byte_cnt == cart_cmd_pkg::PARAM_MID) sram_mask[15:8]  <= rx_byte;
               if (byte_cnt == cart_cmd_pkg::PARAM_LO)  sram_mask[7:0]   <= rx_byte;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Address register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         addr_q <= '0;
      end else if (param_valid && cmd_op_q == cart_cmd_pkg::OP_SET_ADDR &&
                   byte_cnt == cart_cmd_pkg::PARAM_HI) begin
         addr_q <= {rx_byte, 16'h0000};
      end else if (param_valid && cmd_op_q == cart_cmd_pkg::OP_SET_ADDR &&
                   byte_cnt == cart_cmd_pkg::PARAM_MID) begin
         addr_q[15:8] <= rx_byte;
      end else if (param_valid && cmd_op_q == cart_cmd_pkg::OP_SET_ADDR &&
                   byte_cnt == cart_cmd_pkg::PARAM_LO) begin
         addr_q[7:0] <= rx_byte;
      end else if (dma_step || inc_now) begin
         addr_q <= addr_q + cart_cmd_pkg::ADDR_STEP;
      end
   end

   // Strobes, fetch pipeline and transmit byte
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wdata_q     <= 8'd0;
         we_q        <= 1'b1;
         rd_pend_q   <= 1'b0;
         fetch_q     <= 1'b0;
         bit_cnt_q   <= 3'd0;
         dma_nx_sync <= 3'b000;
         tx_byte     <= 8'd0;
         tx_load     <= 1'b0;
      end else begin
         we_q        <= !(param_valid && cmd_op_q == cart_cmd_pkg::OP_WRITE);
         rd_pend_q   <= cmd_valid && rx_op == cart_cmd_pkg::OP_READ;
         fetch_q     <= fetch_now;
         bit_cnt_q   <= bit_cnt;
         dma_nx_sync <= {dma_nx_sync[1:0], dma_nextaddr};
         tx_load     <= 1'b0;
         if (param_valid) begin
            wdata_q <= rx_byte;
         end
         if (cmd_valid && rx_op == cart_cmd_pkg::OP_ECHO) begin
            tx_byte <= cart_cmd_pkg::ECHO_BYTE;
            tx_load <= 1'b1;
         end else if (fetch_q) begin
            tx_byte <= mem_rdata;
            tx_load <= 1'b1;
         end
      end
   end

   // DMA takes the write port while override is high
   assign mem_addr  = addr_q[cart_cmd_pkg::MEM_AW-1:0];
   assign mem_wdata = dma_ovr ? dma_data : wdata_q;
   assign mem_we_n  = dma_ovr ? ~dma_we : we_q;
   assign mem_re_n  = ~fetch_now;

   a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
      !dma_ovr |-> (mem_we_n || mem_re_n));

   a_re_single: assert property (@(posedge clk) disable iff (!rst_n)
      !mem_re_n |=> mem_re_n);

   a_we_single: assert property (@(posedge clk) disable iff (!rst_n)
      (!dma_ovr && !mem_we_n) |=> (mem_we_n || dma_ovr));

   a_idle_addr: assert property (@(posedge clk) disable iff (!rst_n)
      ($past(phase_q) == cart_cmd_pkg::PH_IDLE && !$past(dma_step)) |->
      $stable(addr_q));

endmodule

// File: design/cart_mem.sv
`timescale 1ns/1ns

module cart_mem (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [cart_cmd_pkg::MEM_AW-1:0] addr,
   input  logic [7:0]                      wdata,
   input  logic                            we_n,
   input  logic                            re_n,
   output logic [7:0]                      rdata
);

   ////////////////////////////////////////////////////////////////////////////
   // Behavioural cartridge storage
   ////////////////////////////////////////////////////////////////////////////

   // 4 KiB of byte storage
   logic [7:0] mem [cart_cmd_pkg::MEM_DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (!we_n) begin
         mem[addr] <= wdata;
      end
   end

   // Read port, data valid the cycle after the strobe
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rdata <= 8'd0;
      end else if (!re_n) begin
         // Old contents returned on a same-cycle write
         rdata <= mem[addr];
      end
   end

endmodule

// File: design/cart_cmd_top.sv
`timescale 1ns/1ns

module cart_cmd_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            spi_sck,
   input  logic                            spi_mosi,
   input  logic                            spi_ss_n,
   output logic                            spi_miso,
   input  logic                            dma_ovr,
   input  logic                            dma_we,
   input  logic [7:0]                      dma_data,
   input  logic                            dma_nextaddr,
   output logic [3:0]                      mapper,
   output logic [cart_cmd_pkg::ADDR_W-1:0] rom_mask,
   output logic [cart_cmd_pkg::ADDR_W-1:0] sram_mask
);

   // SPI slave to decoder
   logic [7:0]                          rx_byte;
   logic                                byte_valid;
   logic [2:0]                          bit_cnt;
   logic [cart_cmd_pkg::BYTE_CNT_W-1:0] byte_cnt;
   logic                                xfer_start;
   logic                                xfer_end;
   logic [7:0]                          tx_byte;
   logic                                tx_load;

   // Decoder to memory
   logic [cart_cmd_pkg::MEM_AW-1:0]     mem_addr;
   logic [7:0]                          mem_wdata;
   logic                                mem_we_n;
   logic                                mem_re_n;
   logic [7:0]                          mem_rdata;

   spi_byte_slave u_spi (
      .clk        (clk),
      .rst_n      (rst_n),
      .spi_sck    (spi_sck),
      .spi_mosi   (spi_mosi),
      .spi_ss_n   (spi_ss_n),
      .spi_miso   (spi_miso),
      .tx_byte    (tx_byte),
      .tx_load    (tx_load),
      .rx_byte    (rx_byte),
      .byte_valid (byte_valid),
      .bit_cnt    (bit_cnt),
      .byte_cnt   (byte_cnt),
      .xfer_start (xfer_start),
      .xfer_end   (xfer_end)
   );

   mcu_cmd u_cmd (
      .clk          (clk),
      .rst_n        (rst_n),
      .rx_byte      (rx_byte),
      .byte_valid   (byte_valid),
      .bit_cnt      (bit_cnt),
      .byte_cnt     (byte_cnt),
      .xfer_start   (xfer_start),
      .xfer_end     (xfer_end),
      .tx_byte      (tx_byte),
      .tx_load      (tx_load),
      .mem_addr     (mem_addr),
      .mem_wdata    (mem_wdata),
      .mem_we_n     (mem_we_n),
      .mem_re_n     (mem_re_n),
      .mem_rdata    (mem_rdata),
      .dma_ovr      (dma_ovr),
      .dma_we       (dma_we),
      .dma_data     (dma_data),
      .dma_nextaddr (dma_nextaddr),
      .mapper       (mapper),
      .rom_mask     (rom_mask),
      .sram_mask    (sram_mask)
   );

   cart_mem u_mem (
      .clk   (clk),
      .rst_n (rst_n),
      .addr  (mem_addr),
      .wdata (mem_wdata),
      .we_n  (mem_we_n),
      .re_n  (mem_re_n),
      .rdata (mem_rdata)
   );

endmodule

// File: test/tb_cart_cmd.sv
`timescale 1ns/1ns

module tb_cart_cmd;

   localparam int CLK_NS      = 4;
   localparam int PHASE_CLK   = 6;
   localparam int BIT_CLK     = 2 * PHASE_CLK;
   localparam int CFG_ROUNDS  = 8;
   localparam int BURST_MAX   = 32;
   localparam int PREFILL_LEN = 4;
   localparam int NI_BYTES    = 5;
   localparam int ECHO_LEN    = 8;
   localparam int DMA_LEN     = 16;
   localparam int DMA_CLK     = 9;
   localparam int MARGIN_CLK  = 2000;

   // Upper bound on SPI bytes over all five tests
   localparam int TOTAL_BYTES = CFG_ROUNDS * 10 + 2 * (5 + BURST_MAX) +
                                3 * 4 + 2 * (1 + PREFILL_LEN) + (1 + NI_BYTES) +
                                (1 + ECHO_LEN) + 8 + 1 + DMA_LEN;
   localparam int WATCHDOG_NS = (TOTAL_BYTES * 8 * BIT_CLK + DMA_LEN * DMA_CLK +
                                 MARGIN_CLK) * CLK_NS;

   logic        clk;
   logic        rst_n;
   logic        spi_sck;
   logic        spi_mosi;
   logic        spi_ss_n;
   logic        spi_miso;
   logic        dma_ovr;
   logic        dma_we;
   logic [7:0]  dma_data;
   logic        dma_nextaddr;
   logic [3:0]  mapper;
   logic [23:0] rom_mask;
   logic [23:0] sram_mask;

   // Reference model state
   logic [7:0]  m_mem [cart_cmd_pkg::MEM_DEPTH];
   logic [23:0] m_addr;
   logic [23:0] m_rom_mask;
   logic [23:0] m_sram_mask;
   logic [3:0]  m_mapper;
   logic [7:0]  burst [$];
   int          errors;
   int          checks;

   cart_cmd_top DUT (
      .clk          (clk),
      .rst_n        (rst_n),
      .spi_sck      (spi_sck),
      .spi_mosi     (spi_mosi),
      .spi_ss_n     (spi_ss_n),
      .spi_miso     (spi_miso),
      .dma_ovr      (dma_ovr),
      .dma_we       (dma_we),
      .dma_data     (dma_data),
      .dma_nextaddr (dma_nextaddr),
      .mapper       (mapper),
      .rom_mask     (rom_mask),
      .sram_mask    (sram_mask)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   // Inputs always change 1 ns after the rising edge
   task automatic tick(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic check_value(input string name, input logic [23:0] got,
                              input logic [23:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %s got 0x%0h exp 0x%0h", name, got, exp);
         errors++;
      end
   endtask

   function automatic logic [7:0] cmd_byte(input cart_cmd_pkg::cmd_op_e op,
                                           input logic [3:0] lo);
      return {op, lo};
   endfunction

   task automatic spi_begin();
      spi_sck  = 1'b0;
      spi_ss_n = 1'b0;
      tick(4);
   endtask

   task automatic spi_end();
      spi_sck = 1'b0;
      tick(PHASE_CLK);
      spi_ss_n = 1'b1;
      tick(8);
   endtask

   // Mode 0, MSB first; MISO sampled at the end of the low phase
   task automatic spi_xfer(input logic [7:0] mosi_byte, output logic [7:0] miso_byte);
      for (int i = 7; i >= 0; i--) begin
         spi_sck  = 1'b0;
         spi_mosi = mosi_byte[i];
         tick(PHASE_CLK);
         miso_byte[i] = spi_miso;
         spi_sck = 1'b1;
         tick(PHASE_CLK);
      end
   endtask

   task automatic send_reg24(input cart_cmd_pkg::cmd_op_e op, input logic [23:0] val);
      logic [7:0] rx;
      spi_begin();
      spi_xfer(cmd_byte(op, 4'h0), rx);
      spi_xfer(val[23:16], rx);
      spi_xfer(val[15:8], rx);
      spi_xfer(val[7:0], rx);
      spi_end();
   endtask

   task automatic set_addr(input logic [23:0] a);
      send_reg24(cart_cmd_pkg::OP_SET_ADDR, a);
      m_addr = a;
   endtask

   task automatic set_mapper(input logic [3:0] n);
      logic [7:0] rx;
      spi_begin();
      spi_xfer(cmd_byte(cart_cmd_pkg::OP_SET_MAPPER, n), rx);
      spi_end();
      m_mapper = n;
   endtask

   task automatic check_config();
      check_value("mapper", mapper, m_mapper);
      check_value("rom_mask", rom_mask, m_rom_mask);
      check_value("sram_mask", sram_mask, m_sram_mask);
   endtask

   // Sends the bytes queued in burst as one WRITE transfer
   task automatic write_burst(input bit inc);
      logic [7:0] rx;
      spi_begin();
      spi_xfer(cmd_byte(cart_cmd_pkg::OP_WRITE, {3'b000, inc}), rx);
      foreach (burst[i]) begin
         spi_xfer(burst[i], rx);
         m_mem[m_addr[cart_cmd_pkg::MEM_AW-1:0]] = burst[i];
         if (inc) m_addr = m_addr + 24'd1;
      end
      spi_end();
   endtask

   task automatic read_check(input bit inc, input int n);
      logic [7:0] rx;
      logic [7:0] exp_byte;
      spi_begin();
      spi_xfer(cmd_byte(cart_cmd_pkg::OP_READ, {3'b000, inc}), rx);
      for (int i = 0; i < n; i++) begin
         exp_byte = m_mem[m_addr[cart_cmd_pkg::MEM_AW-1:0]];
         if (inc) m_addr = m_addr + 24'd1;
         spi_xfer(8'($urandom), rx);
         check_value("spi_miso", rx, exp_byte);
      end
      // One fetch runs ahead of the last byte clocked out
      if (inc) m_addr = m_addr + 24'd1;
      spi_end();
   endtask

   task automatic fill_burst(input int n);
      burst.delete();
      repeat (n) burst.push_back(8'($urandom));
   endtask

   // One DMA write, then optionally one address step
   task automatic dma_step(input logic [7:0] data, input bit advance);
      dma_data = data;
      dma_we   = 1'b1;
      tick(1);
      dma_we = 1'b0;
      m_mem[m_addr[cart_cmd_pkg::MEM_AW-1:0]] = data;
      if (advance) begin
         dma_nextaddr = 1'b1;
         tick(4);
         dma_nextaddr = 1'b0;
         tick(4);
         m_addr = m_addr + 24'd1;
      end
   endtask

   task automatic report_test(input string name, input int err_before);
      $display("%-28s done, %0d errors", name, errors - err_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int         seed_val;
      int         err_mark;
      int         len;
      logic [23:0] start;
      logic [7:0]  rx;
      seed_val     = $urandom(32'h4974);
      errors       = 0;
      checks       = 0;
      rst_n        = 1'b0;
      spi_sck      = 1'b0;
      spi_mosi     = 1'b0;
      spi_ss_n     = 1'b1;
      dma_ovr      = 1'b0;
      dma_we       = 1'b0;
      dma_data     = 8'h00;
      dma_nextaddr = 1'b0;
      m_addr       = 24'h0;
      m_mapper     = 4'h0;
      m_rom_mask   = 24'hFFFFFF;
      m_sram_mask  = 24'hFFFFFF;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
      tick(2);

      // 1. Configuration registers, starting from reset values
      err_mark = errors;
      check_config();
      check_value("spi_miso", spi_miso, 24'h0);
      for (int r = 0; r < CFG_ROUNDS; r++) begin
         set_mapper(4'($urandom));
         check_config();
         m_rom_mask = 24'($urandom);
         send_reg24(cart_cmd_pkg::OP_SET_ROM_MASK, m_rom_mask);
         check_config();
         m_sram_mask = 24'($urandom);
         send_reg24(cart_cmd_pkg::OP_SET_SRAM_MASK, m_sram_mask);
         check_config();
      end
      report_test("config", err_mark);

      // 2. Auto-increment burst write and read back
      err_mark = errors;
      start    = 24'($urandom);
      len      = $urandom_range(4, BURST_MAX);
      fill_burst(len);
      set_addr(start);
      write_burst(1'b1);
      set_addr(start);
      read_check(1'b1, len);
      report_test("auto-increment burst", err_mark);

      // 3. Prefill, then repeated writes to one address
      err_mark = errors;
      start    = 24'($urandom);
      fill_burst(PREFILL_LEN);
      set_addr(start);
      write_burst(1'b1);
      fill_burst(NI_BYTES);
      set_addr(start + 24'd1);
      write_burst(1'b0);
      set_addr(start);
      read_check(1'b1, PREFILL_LEN);
      report_test("non-incrementing write", err_mark);

      // 4. Echo probe
      err_mark = errors;
      spi_begin();
      spi_xfer(cmd_byte(cart_cmd_pkg::OP_ECHO, 4'h0), rx);
      for (int i = 0; i < ECHO_LEN; i++) begin
         spi_xfer(8'($urandom), rx);
         check_value("spi_miso", rx, 8'hA5);
      end
      spi_end();
      report_test("echo", err_mark);

      // 5. DMA override writes, read back over SPI
      err_mark = errors;
      start    = 24'($urandom);
      set_addr(start);
      dma_ovr = 1'b1;
      tick(1);
      for (int i = 0; i < DMA_LEN; i++) begin
         dma_step(8'($urandom), i != DMA_LEN - 1);
      end
      dma_ovr = 1'b0;
      tick(2);
      set_addr(start);
      read_check(1'b1, DMA_LEN);
      report_test("DMA override", err_mark);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: tb.f
design/cart_cmd_pkg.sv
design/spi_byte_slave.sv
design/mcu_cmd.sv
design/cart_mem.sv
design/cart_cmd_top.sv
test/tb_cart_cmd.sv

// File: Bender.yml
package:
  name: cart_cmd

sources:
  - design/cart_cmd_pkg.sv
  - design/spi_byte_slave.sv
  - design/mcu_cmd.sv
  - design/cart_mem.sv
  - design/cart_cmd_top.sv
  - target: test
    files:
      - test/tb_cart_cmd.sv
